// File: rtl/mem_pkg.sv
package mem_pkg;

    // byte address and data word
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // 4 KB per memory
    localparam int depth_words = 1024;
    // word index from addr[11:2]
    localparam int idx_w = 10;

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [idx_w-1:0]  idx_t;

    // one data memory access
    typedef struct packed {
        logic                  ena;
        // one bit per byte lane
        logic [word_w/8-1:0]   wea;
        addr_t                 addr;
        word_t                 wdata;
    } data_req_t;

    // one loader write into instruction memory
    typedef struct packed {
        logic  en;
        idx_t  idx;
        word_t data;
    } load_req_t;

endpackage

// File: rtl/fetch_pkg.sv
package fetch_pkg;

    // first fetch after reset
    localparam mem_pkg::addr_t reset_pc = '0;

    // two words per fetch
    localparam mem_pkg::addr_t fetch_step = mem_pkg::addr_t'(8);

    // fetch control states
    typedef enum logic [1:0] {
        idle,
        run,
        hold,
        load
    } fetch_state_t;

    // valid is a single-cycle pulse
    typedef struct packed {
        logic           valid;
        mem_pkg::addr_t pc;
    } redirect_t;

    // what the core sees each cycle
    typedef struct packed {
        mem_pkg::addr_t pc;
        // word at pc
        mem_pkg::word_t inst_1;
        // word at pc + 4
        mem_pkg::word_t inst_2;
        logic           ok_1;
        // low when pc + 4 would wrap past the end
        logic           ok_2;
    } fetch_bundle_t;

endpackage

// File: rtl/fetch_fsm.sv
`timescale 1ns/100ps

module fetch_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_en,
    input  logic           stall,
    input  logic           load_en,
    input  logic           redirect_valid,
    input  mem_pkg::addr_t next_pc,
    output logic           issue,
    output logic           take_redirect,
    output logic           inst_ena,
    output mem_pkg::addr_t bundle_pc,
    output logic           ok_1,
    output logic           ok_2
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    logic                    last_word;

    // loader over enable over back-pressure
    always_comb begin
        if (load_en) begin
            state_next = fetch_pkg::load;
        end else if (!fetch_en) begin
            state_next = fetch_pkg::idle;
        end else if (stall) begin
            state_next = fetch_pkg::hold;
        end else begin
            state_next = fetch_pkg::run;
        end
    end

    // fetch goes out in the same cycle the inputs allow it
    // never while reset is held
    assign issue = rst && (state_next == fetch_pkg::run);
    assign inst_ena = issue;

    // redirect (fresh or stored) steers this cycle's fetch
    assign take_redirect = issue & redirect_valid;

    // second word of the pair would wrap to index 0
    assign last_word = (next_pc[mem_pkg::idx_w+1:2] == mem_pkg::idx_t'(mem_pkg::depth_words - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= fetch_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // ok flags track the fetch now in the RAM output registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            ok_1 <= 1'b0;
            ok_2 <= 1'b0;
        end else if (issue) begin
            ok_1 <= 1'b1;
            ok_2 <= ~last_word;
        end else if (state == fetch_pkg::idle || state == fetch_pkg::load) begin
            // one cycle after leaving run
            ok_1 <= 1'b0;
            ok_2 <= 1'b0;
        end
    end

    // bundle pc held through stalls
    always_ff @(posedge clk) begin
        if (issue) begin
            bundle_pc <= next_pc;
        end
    end

endmodule

// File: rtl/pc_counter.sv
`timescale 1ns/100ps

module pc_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  logic                 take_redirect,
    input  fetch_pkg::redirect_t redirect,
    output mem_pkg::addr_t       next_pc,
    output logic                 redirect_pending
);

    mem_pkg::addr_t pc_q;
    mem_pkg::addr_t pend_pc;
    mem_pkg::addr_t target;
    mem_pkg::addr_t stepped;

    // a fresh pulse beats the stored target
    assign target = redirect.valid ? redirect.pc : pend_pc;
    assign next_pc = take_redirect ? target : pc_q;

    // keep within the 4 KB of memory
    assign stepped = (next_pc + fetch_pkg::fetch_step)
                   & mem_pkg::addr_t'(mem_pkg::depth_words * 4 - 1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_q             <= fetch_pkg::reset_pc;
            redirect_pending <= 1'b0;
        end else if (issue) begin
            pc_q             <= stepped;
            redirect_pending <= 1'b0;
        end else if (redirect.valid) begin
            // no fetch this cycle, remember it
            redirect_pending <= 1'b1;
        end
    end

    // target of a redirect seen while fetch was blocked
    always_ff @(posedge clk) begin
        if (!issue && redirect.valid) begin
            pend_pc <= redirect.pc;
        end
    end

endmodule

// File: rtl/dual_inst_ram.sv
`timescale 1ns/100ps

module dual_inst_ram (
    input  logic               clk,
    input  logic               ena,
    input  mem_pkg::addr_t     pc,
    input  mem_pkg::load_req_t load,
    output mem_pkg::word_t     rdata_1,
    output mem_pkg::word_t     rdata_2
);

    mem_pkg::word_t mem [mem_pkg::depth_words];

    mem_pkg::addr_t pc_plus_4;
    mem_pkg::idx_t  idx_a;
    mem_pkg::idx_t  idx_b;

    // port a at pc
    assign idx_a = pc[mem_pkg::idx_w+1:2];

    // port b one word up, index wraps on its own width
    assign pc_plus_4 = pc + mem_pkg::addr_t'(4);
    assign idx_b = pc_plus_4[mem_pkg::idx_w+1:2];

    // loader shares port a
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.idx] <= load.data;
        end
    end

    // both words registered together
    // outputs hold while ena is low
    always_ff @(posedge clk) begin
        if (ena) begin
            rdata_1 <= mem[idx_a];
            rdata_2 <= mem[idx_b];
        end
    end

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/100ps

module data_ram (
    input  logic               clk,
    input  mem_pkg::data_req_t req,
    output mem_pkg::word_t     rdata
);

    mem_pkg::word_t mem [mem_pkg::depth_words];

    mem_pkg::idx_t idx;

    // word index from the byte address
    assign idx = req.addr[mem_pkg::idx_w+1:2];

    // read-first: a write and a read in one cycle return the old word
    always_ff @(posedge clk) begin
        if (req.ena) begin
            for (int b = 0; b < mem_pkg::word_w / 8; b++) begin
                // only enabled lanes change
                if (req.wea[b]) begin
                    mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
            rdata <= mem[idx];
        end
    end

endmodule

// File: rtl/mem_top.sv
`timescale 1ns/100ps

module mem_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_en,
    input  logic                     stall,
    input  fetch_pkg::redirect_t     redirect,
    input  mem_pkg::load_req_t       load,
    input  mem_pkg::data_req_t       data_req,
    output fetch_pkg::fetch_bundle_t fetch,
    output mem_pkg::word_t           data_rdata
);

    logic           issue;
    logic           take_redirect;
    logic           inst_ena;
    logic           redirect_pending;
    logic           redirect_any;
    logic           ok_1;
    logic           ok_2;
    mem_pkg::addr_t next_pc;
    mem_pkg::addr_t bundle_pc;
    mem_pkg::word_t inst_rdata_1;
    mem_pkg::word_t inst_rdata_2;

    // live pulse or one held over a stall
    assign redirect_any = redirect.valid | redirect_pending;

    fetch_fsm u_fetch_fsm (
        .clk            (clk           ),
        .rst            (rst           ),
        .fetch_en       (fetch_en      ),
        .stall          (stall         ),
        .load_en        (load.en       ),
        .redirect_valid (redirect_any  ),
        .next_pc        (next_pc       ),
        .issue          (issue         ),
        .take_redirect  (take_redirect ),
        .inst_ena       (inst_ena      ),
        .bundle_pc      (bundle_pc     ),
        .ok_1           (ok_1          ),
        .ok_2           (ok_2          )
    );

    pc_counter u_pc_counter (
        .clk              (clk             ),
        .rst              (rst             ),
        .issue            (issue           ),
        .take_redirect    (take_redirect   ),
        .redirect         (redirect        ),
        .next_pc          (next_pc         ),
        .redirect_pending (redirect_pending)
    );

    dual_inst_ram u_dual_inst_ram (
        .clk     (clk         ),
        .ena     (inst_ena    ),
        .pc      (next_pc     ),
        .load    (load        ),
        .rdata_1 (inst_rdata_1),
        .rdata_2 (inst_rdata_2)
    );

    data_ram u_data_ram (
        .clk   (clk       ),
        .req   (data_req  ),
        .rdata (data_rdata)
    );

    // bundle to the core
    assign fetch = '{
        pc:     bundle_pc,
        inst_1: inst_rdata_1,
        inst_2: inst_rdata_2,
        ok_1:   ok_1,
        ok_2:   ok_2
    };

endmodule

// File: verif/mem_top_checker.sv
`timescale 1ns/100ps

module mem_top_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     stall,
    input logic                     inst_ena,
    input mem_pkg::load_req_t       load,
    input fetch_pkg::fetch_bundle_t fetch
);

    // failures so far, the testbench adds them to its own count
    int unsigned fail_count = 0;

    // reset clears both flags
    a_reset_clears_ok: assert property (@(posedge clk)
        !rst |=> (!fetch.ok_1 && !fetch.ok_2))
        else begin
            fail_count++;
            $error("ok flags still set in the cycle after reset");
        end

    // second word never valid without the first
    a_ok_2_needs_ok_1: assert property (@(posedge clk) disable iff (!rst)
        fetch.ok_2 |-> fetch.ok_1)
        else begin
            fail_count++;
            $error("ok_2 high while ok_1 is low");
        end

    // back-pressure freezes pc and both words
    a_stall_holds_bundle: assert property (@(posedge clk) disable iff (!rst)
        (stall && fetch.ok_1) |=> $stable({fetch.pc, fetch.inst_1, fetch.inst_2}))
        else begin
            fail_count++;
            $error("fetch bundle changed during stall");
        end

    // loader owns the instruction memory
    a_no_fetch_during_load: assert property (@(posedge clk) disable iff (!rst)
        load.en |-> !inst_ena)
        else begin
            fail_count++;
            $error("instruction fetch issued while the loader writes");
        end

endmodule

// File: verif/tb_mem_top.sv
`timescale 1ns/100ps

module tb_mem_top;

    localparam int reset_cycles = 16;
    localparam int data_ops = 80;
    // loader pass, fetch scenarios, data traffic
    localparam int test_cycles = reset_cycles + mem_pkg::depth_words + 220 + 16 + data_ops;
    localparam int margin_ns = 800;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     fetch_en;
    logic                     stall;
    fetch_pkg::redirect_t     redirect;
    mem_pkg::load_req_t       load;
    mem_pkg::data_req_t       data_req;
    fetch_pkg::fetch_bundle_t fetch;
    mem_pkg::word_t           data_rdata;

    // shadow memories
    mem_pkg::word_t imem [mem_pkg::depth_words];
    mem_pkg::word_t dmem [mem_pkg::depth_words];

    // model state
    fetch_pkg::fetch_bundle_t exp_fetch;
    mem_pkg::addr_t           m_pc;
    mem_pkg::addr_t           m_pend_pc;
    mem_pkg::addr_t           fetch_addr;
    logic                     m_pend;
    // fetch state is idle or load
    logic                     m_off;
    mem_pkg::word_t           exp_rdata;
    logic                     rd_valid = 1'b0;
    mem_pkg::idx_t            d_idx;
    mem_pkg::word_t           d_mask;

    mem_pkg::word_t lfsr_state = 32'd71952;
    int checks = 0;
    int errors = 0;

    mem_top i_mem_top (
        .clk        (clk       ),
        .rst        (rst       ),
        .fetch_en   (fetch_en  ),
        .stall      (stall     ),
        .redirect   (redirect  ),
        .load       (load      ),
        .data_req   (data_req  ),
        .fetch      (fetch     ),
        .data_rdata (data_rdata)
    );

    bind mem_top mem_top_checker u_checker (
        .clk      (clk     ),
        .rst      (rst     ),
        .stall    (stall   ),
        .inst_ena (inst_ena),
        .load     (load    ),
        .fetch    (fetch   )
    );

    // 4 ns period
    always #2 clk = ~clk;

    // right-shift galois form, taps 32 30 26 25
    function automatic mem_pkg::word_t lfsr_step(input mem_pkg::word_t s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic mem_pkg::word_t take_bits(input int n);
        mem_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[mem_pkg::word_w-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_pkg::addr_t word_addr(input mem_pkg::idx_t idx);
        return mem_pkg::addr_t'(idx) << 2;
    endfunction

    function automatic mem_pkg::addr_t random_word_addr();
        mem_pkg::idx_t idx;
        idx = mem_pkg::idx_t'(take_bits(mem_pkg::idx_w));
        return word_addr(idx);
    endfunction

    // byte enables spread to a bit mask
    function automatic mem_pkg::word_t lane_mask(input logic [3:0] lanes);
        return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    endfunction

    // expected bundle for a fetch at pc
    function automatic fetch_pkg::fetch_bundle_t predict_fetch(input mem_pkg::addr_t pc);
        fetch_pkg::fetch_bundle_t b;
        int                       first;
        int                       second;
        first = int'((pc / 4) % mem_pkg::depth_words);
        // pair wraps to word 0 at the top
        second = (first + 1) % mem_pkg::depth_words;
        b.pc = pc;
        b.inst_1 = imem[first];
        b.inst_2 = imem[second];
        b.ok_1 = 1'b1;
        b.ok_2 = (first != mem_pkg::depth_words - 1);
        return b;
    endfunction

    task automatic check_value(input string what, input mem_pkg::word_t got,
                               input mem_pkg::word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // drive point 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_redirect(input mem_pkg::addr_t target);
        redirect = '{valid: 1'b1, pc: target};
        next_cycle();
        redirect = '0;
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_pkg::depth_words; i++) begin
            load = '{en: 1'b1, idx: mem_pkg::idx_t'(i), data: take_bits(mem_pkg::word_w)};
            next_cycle();
        end
        load = '0;
    endtask

    task automatic data_access(input logic [3:0] lanes, input mem_pkg::idx_t idx,
                               input mem_pkg::word_t value);
        data_req = '{ena: 1'b1, wea: lanes, addr: word_addr(idx), wdata: value};
        next_cycle();
    endtask

    task automatic data_test();
        mem_pkg::idx_t base;
        mem_pkg::idx_t idx;
        logic [3:0]    lanes;
        // 16-word window at a random spot
        base = mem_pkg::idx_t'(take_bits(6) << 4);
        for (int k = 0; k < 16; k++) begin
            data_access(4'hf, base + mem_pkg::idx_t'(k), take_bits(mem_pkg::word_w));
        end
        // mixed reads and partial writes, back to back
        for (int k = 0; k < data_ops; k++) begin
            idx = base + mem_pkg::idx_t'(take_bits(4));
            if (take_bits(1) == 1) begin
                lanes = 4'(take_bits(4));
            end else begin
                lanes = 4'h0;
            end
            data_access(lanes, idx, take_bits(mem_pkg::word_w));
        end
        data_req = '0;
    endtask

    // reference model, advanced at each edge
    always @(posedge clk) begin
        if (!rst) begin
            m_pc = fetch_pkg::reset_pc;
            m_pend = 1'b0;
            m_off = 1'b1;
            exp_fetch.ok_1 = 1'b0;
            exp_fetch.ok_2 = 1'b0;
        end else begin
            if (fetch_en && !stall && !load.en) begin
                // fresh redirect, then stored one, then sequential
                if (redirect.valid) begin
                    fetch_addr = redirect.pc;
                end else if (m_pend) begin
                    fetch_addr = m_pend_pc;
                end else begin
                    fetch_addr = m_pc;
                end
                exp_fetch = predict_fetch(fetch_addr);
                m_pc = (fetch_addr + fetch_pkg::fetch_step)
                     % mem_pkg::addr_t'(mem_pkg::depth_words * 4);
                m_pend = 1'b0;
            end else begin
                if (redirect.valid) begin
                    m_pend = 1'b1;
                    m_pend_pc = redirect.pc;
                end
                // flags drop one cycle after leaving run
                if (m_off) begin
                    exp_fetch.ok_1 = 1'b0;
                    exp_fetch.ok_2 = 1'b0;
                end
            end
            m_off = load.en || !fetch_en;
            if (load.en) begin
                imem[load.idx] = load.data;
            end
        end
        // data memory returns the word from before the write
        if (data_req.ena) begin
            d_idx = mem_pkg::idx_t'((data_req.addr / 4) % mem_pkg::depth_words);
            d_mask = lane_mask(data_req.wea);
            exp_rdata = dmem[d_idx];
            rd_valid = 1'b1;
            dmem[d_idx] = (dmem[d_idx] & ~d_mask) | (data_req.wdata & d_mask);
        end
    end

    // compare away from the edge
    always @(negedge clk) begin
        if (rst) begin
            check_value("ok_1", mem_pkg::word_t'(fetch.ok_1), mem_pkg::word_t'(exp_fetch.ok_1));
            check_value("ok_2", mem_pkg::word_t'(fetch.ok_2), mem_pkg::word_t'(exp_fetch.ok_2));
            // words only mean something with ok_1
            if (exp_fetch.ok_1) begin
                check_value("bundle pc", fetch.pc, exp_fetch.pc);
                check_value("inst_1", fetch.inst_1, exp_fetch.inst_1);
                check_value("inst_2", fetch.inst_2, exp_fetch.inst_2);
            end
            if (rd_valid) begin
                check_value("data_rdata", data_rdata, exp_rdata);
            end
        end
    end

    initial begin
        #(test_cycles * 4 + margin_ns);
        $display("timeout: the run did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b0;
        fetch_en = 1'b0;
        stall = 1'b0;
        redirect = '0;
        load = '0;
        data_req = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b1;

        // out of reset, nothing fetched yet
        repeat (4) next_cycle();
        load_program();

        // straight-line dual fetch
        fetch_en = 1'b1;
        repeat (40) next_cycle();

        // redirects while running
        for (int r = 0; r < 8; r++) begin
            pulse_redirect(random_word_addr());
            repeat (4) next_cycle();
        end
        pulse_redirect(random_word_addr());
        pulse_redirect(random_word_addr());
        repeat (4) next_cycle();

        // redirect caught by a stall
        stall = 1'b1;
        repeat (2) next_cycle();
        pulse_redirect(random_word_addr());
        repeat (3) next_cycle();
        stall = 1'b0;
        repeat (6) next_cycle();

        // plain stall
        stall = 1'b1;
        repeat (5) next_cycle();
        stall = 1'b0;
        repeat (4) next_cycle();

        // fetch off, then back on
        fetch_en = 1'b0;
        repeat (4) next_cycle();
        fetch_en = 1'b1;
        repeat (6) next_cycle();

        // last word, then the pair just below it
        pulse_redirect(word_addr(mem_pkg::idx_t'(mem_pkg::depth_words - 1)));
        repeat (4) next_cycle();
        pulse_redirect(word_addr(mem_pkg::idx_t'(mem_pkg::depth_words - 2)));
        repeat (4) next_cycle();

        // loader cuts into a running fetch
        for (int k = 0; k < 3; k++) begin
            load = '{en: 1'b1, idx: mem_pkg::idx_t'(take_bits(mem_pkg::idx_w)),
                     data: take_bits(mem_pkg::word_w)};
            next_cycle();
        end
        load = '0;
        repeat (6) next_cycle();
        fetch_en = 1'b0;
        repeat (3) next_cycle();

        data_test();
        repeat (4) next_cycle();

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_mem_top.u_checker.fail_count);
        if (errors == 0 && i_mem_top.u_checker.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_fsm.sv
rtl/pc_counter.sv
rtl/dual_inst_ram.sv
rtl/data_ram.sv
rtl/mem_top.sv
verif/mem_top_checker.sv
verif/tb_mem_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+100
PASS_TEXT = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
